// ==== common/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// ------------------------------
// Data memory geometry
// ------------------------------

// Word address width, 256 words
`define LSU_MEM_AW 8

// ------------------------------
// Bus timing
// ------------------------------

// Cycles of waitrequest at the start of each access
`define LSU_MEM_WAIT 2

`endif

// ==== common/lsu_pkg.sv ====
package lsu_pkg;

    // ------------------------------
    // Data widths
    // ------------------------------

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Bit 3 is byte offset 0, big-endian
    typedef logic [3:0] lanes_t;

    typedef logic [1:0] offset_t;

    // ------------------------------
    // Operations
    // ------------------------------

    typedef enum logic [3:0] {
        OP_FETCH = 4'd0,
        OP_LW    = 4'd1,
        OP_LH    = 4'd2,
        OP_LHU   = 4'd3,
        OP_LB    = 4'd4,
        OP_LBU   = 4'd5,
        OP_SW    = 4'd6,
        OP_SH    = 4'd7,
        OP_SB    = 4'd8
    } mem_op_t;

    // ------------------------------
    // Access stage FSM
    // ------------------------------

    typedef enum logic [1:0] {
        ACC_IDLE = 2'd0,
        ACC_BUS  = 2'd1,
        ACC_DONE = 2'd2
    } access_state_t;

endpackage

// ==== hdl/lsu_issue.sv ====
`include "lsu_defines.svh"

module lsu_issue import lsu_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_valid,
    input  mem_op_t                 cmd_op,
    input  addr_t                   cmd_addr,
    input  word_t                   cmd_wdata,
    input  logic                    iss_ready,
    output logic                    cmd_ready,
    output logic                    iss_valid,
    output mem_op_t                 iss_op,
    output logic [`LSU_MEM_AW-1:0]  iss_word_addr,
    output offset_t                 iss_offset,
    output lanes_t                  iss_lanes,
    output word_t                   iss_wdata
);

    offset_t offset;
    lanes_t  lanes;
    word_t   wdata_placed;

    // Slot free, or emptying this cycle
    assign cmd_ready = !iss_valid || iss_ready;

    assign offset = cmd_addr[1:0];

    // ------------------------------
    // Byte enables
    // ------------------------------

    always_comb begin
        case (cmd_op)
            OP_LH, OP_LHU, OP_SH: begin
                lanes = offset[1] ? 4'b0011 : 4'b1100;
            end
            OP_LB, OP_LBU, OP_SB: begin
                case (offset)
                    2'd0:    lanes = 4'b1000;
                    2'd1:    lanes = 4'b0100;
                    2'd2:    lanes = 4'b0010;
                    default: lanes = 4'b0001;
                endcase
            end
            // Fetch and word accesses
            default: lanes = 4'b1111;
        endcase
    end

    // ------------------------------
    // Store data lane placement
    // ------------------------------

    always_comb begin
        case (cmd_op)
            OP_SW: begin
                wdata_placed = cmd_wdata;
            end
            OP_SH: begin
                if (offset[1]) begin
                    wdata_placed = {16'b0, cmd_wdata[15:0]};
                end else begin
                    wdata_placed = {cmd_wdata[15:0], 16'b0};
                end
            end
            OP_SB: begin
                // Offset 0 lands in the top byte
                wdata_placed = {24'b0, cmd_wdata[7:0]} << (8 * (3 - offset));
            end
            default: wdata_placed = '0;
        endcase
    end

    // Command slot
    always_ff @(posedge clk) begin
        if (reset) begin
            iss_valid <= 1'b0;
        end else if (cmd_valid && cmd_ready) begin
            iss_valid <= 1'b1;
        end else if (iss_ready) begin
            iss_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            iss_op        <= cmd_op;
            iss_word_addr <= cmd_addr[`LSU_MEM_AW+1:2];
            iss_offset    <= offset;
            iss_lanes     <= lanes;
            iss_wdata     <= wdata_placed;
        end
    end

endmodule

// ==== hdl/lsu_access.sv ====
`include "lsu_defines.svh"

module lsu_access import lsu_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    iss_valid,
    input  mem_op_t                 iss_op,
    input  logic [`LSU_MEM_AW-1:0]  iss_word_addr,
    input  offset_t                 iss_offset,
    input  lanes_t                  iss_lanes,
    input  word_t                   iss_wdata,
    input  logic                    mem_waitrequest,
    input  word_t                   mem_readdata,
    output logic                    iss_ready,
    output logic [`LSU_MEM_AW-1:0]  mem_address,
    output logic                    mem_read,
    output logic                    mem_write,
    output lanes_t                  mem_byteenable,
    output word_t                   mem_writedata,
    output logic                    acc_valid,
    output mem_op_t                 acc_op,
    output offset_t                 acc_offset,
    output word_t                   acc_rdata
);

    access_state_t state;
    mem_op_t       op_q;
    logic [`LSU_MEM_AW-1:0] addr_q;
    offset_t       offset_q;
    lanes_t        lanes_q;
    word_t         wdata_q;
    word_t         rdata_q;
    logic          is_store;

    assign is_store = op_q inside {OP_SW, OP_SH, OP_SB};

    assign iss_ready = (state == ACC_IDLE);

    // ------------------------------
    // Bus request
    // ------------------------------

    assign mem_read       = (state == ACC_BUS) && !is_store;
    assign mem_write      = (state == ACC_BUS) && is_store;
    assign mem_address    = addr_q;
    assign mem_byteenable = lanes_q;
    assign mem_writedata  = wdata_q;

    // Loads and fetches only
    assign acc_valid  = (state == ACC_DONE) && !is_store;
    assign acc_op     = op_q;
    assign acc_offset = offset_q;
    assign acc_rdata  = rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ACC_IDLE;
        end else begin
            case (state)
                ACC_IDLE: if (iss_valid) state <= ACC_BUS;
                ACC_BUS:  if (!mem_waitrequest) state <= ACC_DONE;
                default:  state <= ACC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid && iss_ready) begin
            op_q     <= iss_op;
            addr_q   <= iss_word_addr;
            offset_q <= iss_offset;
            lanes_q  <= iss_lanes;
            wdata_q  <= iss_wdata;
        end
        // Read data is valid in the completing cycle
        if (state == ACC_BUS && !mem_waitrequest) begin
            rdata_q <= mem_readdata;
        end
    end

endmodule

// ==== hdl/lsu_align.sv ====
module lsu_align import lsu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    acc_valid,
    input  mem_op_t acc_op,
    input  offset_t acc_offset,
    input  word_t   acc_rdata,
    output logic    rsp_valid,
    output word_t   rsp_data
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    word_t       aligned;

    // Big-endian lane select
    always_comb begin
        case (acc_offset)
            2'd0:    sel_byte = acc_rdata[31:24];
            2'd1:    sel_byte = acc_rdata[23:16];
            2'd2:    sel_byte = acc_rdata[15:8];
            default: sel_byte = acc_rdata[7:0];
        endcase
    end

    // Bit 0 of the offset is ignored for halfwords
    assign sel_half = acc_offset[1] ? acc_rdata[15:0] : acc_rdata[31:16];

    // ------------------------------
    // Extension
    // ------------------------------

    always_comb begin
        case (acc_op)
            OP_LB:   aligned = {{24{sel_byte[7]}}, sel_byte};
            OP_LBU:  aligned = {24'b0, sel_byte};
            OP_LH:   aligned = {{16{sel_half[15]}}, sel_half};
            OP_LHU:  aligned = {16'b0, sel_half};
            // Fetch and LW pass through
            default: aligned = acc_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            rsp_data <= aligned;
        end
    end

endmodule

// ==== mem/data_mem.sv ====
`include "lsu_defines.svh"

module data_mem import lsu_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`LSU_MEM_AW-1:0]  address,
    input  logic                    read,
    input  logic                    write,
    input  lanes_t                  byteenable,
    input  word_t                   writedata,
    output logic                    waitrequest,
    output word_t                   readdata
);

    localparam int DEPTH = 1 << `LSU_MEM_AW;
    localparam int CNT_W = (`LSU_MEM_WAIT > 0) ? $clog2(`LSU_MEM_WAIT + 1) : 1;

    word_t            mem [DEPTH];
    logic [CNT_W-1:0] wait_cnt;
    logic             request;

    assign request = read || write;

    // Stall for the first wait states of every request
    assign waitrequest = request && (wait_cnt != CNT_W'(`LSU_MEM_WAIT));

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (request && waitrequest) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // ------------------------------
    // Storage
    // ------------------------------

    // Lane bit i covers bits 8*i+7 to 8*i
    always_ff @(posedge clk) begin
        if (write && !waitrequest) begin
            for (int i = 0; i < 4; i++) begin
                if (byteenable[i]) begin
                    mem[address][8*i +: 8] <= writedata[8*i +: 8];
                end
            end
        end
    end

    assign readdata = mem[address];

endmodule

// ==== hdl/lsu_top.sv ====
`include "lsu_defines.svh"

module lsu_top import lsu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    cmd_valid,
    input  mem_op_t cmd_op,
    input  addr_t   cmd_addr,
    input  word_t   cmd_wdata,
    output logic    cmd_ready,
    output logic    rsp_valid,
    output word_t   rsp_data
);

    // Issue to access
    logic                   iss_valid;
    logic                   iss_ready;
    mem_op_t                iss_op;
    logic [`LSU_MEM_AW-1:0] iss_word_addr;
    offset_t                iss_offset;
    lanes_t                 iss_lanes;
    word_t                  iss_wdata;

    // Memory bus
    logic [`LSU_MEM_AW-1:0] mem_address;
    logic                   mem_read;
    logic                   mem_write;
    lanes_t                 mem_byteenable;
    word_t                  mem_writedata;
    logic                   mem_waitrequest;
    word_t                  mem_readdata;

    // Access to align
    logic                   acc_valid;
    mem_op_t                acc_op;
    offset_t                acc_offset;
    word_t                  acc_rdata;

    lsu_issue lsu_issue_i (
        .clk(clk), .reset(reset),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr),
        .cmd_wdata(cmd_wdata), .iss_ready(iss_ready), .cmd_ready(cmd_ready),
        .iss_valid(iss_valid), .iss_op(iss_op), .iss_word_addr(iss_word_addr),
        .iss_offset(iss_offset), .iss_lanes(iss_lanes), .iss_wdata(iss_wdata)
    );

    lsu_access lsu_access_i (
        .clk(clk), .reset(reset),
        .iss_valid(iss_valid), .iss_op(iss_op), .iss_word_addr(iss_word_addr),
        .iss_offset(iss_offset), .iss_lanes(iss_lanes), .iss_wdata(iss_wdata),
        .mem_waitrequest(mem_waitrequest), .mem_readdata(mem_readdata),
        .iss_ready(iss_ready), .mem_address(mem_address), .mem_read(mem_read),
        .mem_write(mem_write), .mem_byteenable(mem_byteenable),
        .mem_writedata(mem_writedata), .acc_valid(acc_valid), .acc_op(acc_op),
        .acc_offset(acc_offset), .acc_rdata(acc_rdata)
    );

    lsu_align lsu_align_i (
        .clk(clk), .reset(reset),
        .acc_valid(acc_valid), .acc_op(acc_op), .acc_offset(acc_offset),
        .acc_rdata(acc_rdata), .rsp_valid(rsp_valid), .rsp_data(rsp_data)
    );

    data_mem data_mem_i (
        .clk(clk), .reset(reset),
        .address(mem_address), .read(mem_read), .write(mem_write),
        .byteenable(mem_byteenable), .writedata(mem_writedata),
        .waitrequest(mem_waitrequest), .readdata(mem_readdata)
    );

endmodule

// ==== tests/lsu_assert.sv ====
`include "lsu_defines.svh"

module lsu_assert import lsu_pkg::*; (
    input logic                    clk,
    input logic                    reset,
    input logic                    mem_read,
    input logic                    mem_write,
    input logic                    mem_waitrequest,
    input logic [`LSU_MEM_AW-1:0]  mem_address,
    input lanes_t                  mem_byteenable,
    input word_t                   mem_writedata,
    input logic                    acc_valid
);

    timeunit 1ns;
    timeprecision 1ns;

    int violations = 0;

    a_rw_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write))
    else begin
        violations++;
        $error("mem_read and mem_write high together");
    end

    // Request held until waitrequest drops
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_read || mem_write) && mem_waitrequest |=>
            $stable(mem_address) && $stable(mem_byteenable) &&
            $stable(mem_writedata) && $stable(mem_read) && $stable(mem_write))
    else begin
        violations++;
        $error("Bus request changed while waitrequest was high");
    end

    a_acc_pulse: assert property (@(posedge clk) disable iff (reset)
        acc_valid |=> !acc_valid)
    else begin
        violations++;
        $error("acc_valid high for two cycles");
    end

endmodule

bind lsu_access lsu_assert lsu_assert_i (
    .clk(clk), .reset(reset),
    .mem_read(mem_read), .mem_write(mem_write), .mem_waitrequest(mem_waitrequest),
    .mem_address(mem_address), .mem_byteenable(mem_byteenable),
    .mem_writedata(mem_writedata), .acc_valid(acc_valid)
);

// ==== tests/lsu_tb.sv ====
`include "lsu_defines.svh"

module lsu_tb import lsu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int STEPS = 29;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT = STEPS * (`LSU_MEM_WAIT + 8) + RESET_CYCLES;

    // ------------------------------
    // Test table
    // ------------------------------

    localparam mem_op_t STEP_OP [STEPS] = '{
        // Word stores, then LW and fetch
        OP_SW, OP_SW, OP_SW, OP_LW, OP_FETCH, OP_LW, OP_LW,
        // Byte loads at every offset
        OP_LB, OP_LB, OP_LB, OP_LB, OP_LBU, OP_LBU, OP_LBU, OP_LBU,
        // Byte stores into one word
        OP_SB, OP_LW, OP_SB, OP_SB, OP_LW, OP_SB, OP_LW,
        // Halfword stores at offsets 0 and 2
        OP_SH, OP_LH, OP_LHU, OP_SH, OP_LH, OP_LHU, OP_LW
    };

    localparam addr_t STEP_ADDR [STEPS] = '{
        32'h010, 32'h024, 32'h3fc, 32'h010, 32'h010, 32'h024, 32'h3fc,
        32'h010, 32'h011, 32'h012, 32'h013, 32'h010, 32'h011, 32'h012, 32'h013,
        32'h024, 32'h024, 32'h025, 32'h026, 32'h024, 32'h027, 32'h024,
        32'h3fc, 32'h3fc, 32'h3fc, 32'h3fe, 32'h3fe, 32'h3ff, 32'h3fc
    };

    logic    clk = 1'b0;
    logic    reset;
    logic    cmd_valid;
    mem_op_t cmd_op;
    addr_t   cmd_addr;
    word_t   cmd_wdata;
    logic    cmd_ready;
    logic    rsp_valid;
    word_t   rsp_data;

    integer  seed = 94;
    word_t   model [1 << `LSU_MEM_AW];
    word_t   expected_q [$];
    int      load_count = 0;
    int      rsp_count = 0;
    int      cycles = 0;

    lsu_top lsu_top_i (
        .clk(clk), .reset(reset),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr),
        .cmd_wdata(cmd_wdata), .cmd_ready(cmd_ready),
        .rsp_valid(rsp_valid), .rsp_data(rsp_data)
    );

    always #50 clk = ~clk;

    // Byte 0 is the top byte of a word
    task automatic store_to_model(input mem_op_t op, input addr_t addr, input word_t data);
        int w;
        int o;
        w = addr[`LSU_MEM_AW+1:2];
        o = addr[1:0];
        case (op)
            OP_SW: model[w] = data;
            OP_SH: begin
                o = addr[1] ? 2 : 0;
                model[w][31-8*o -: 8] = data[15:8];
                model[w][23-8*o -: 8] = data[7:0];
            end
            default: model[w][31-8*o -: 8] = data[7:0];
        endcase
    endtask

    function automatic word_t expected_load(input mem_op_t op, input addr_t addr);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        int          o;
        w = model[addr[`LSU_MEM_AW+1:2]];
        o = addr[1:0];
        b = w[31-8*o -: 8];
        h = addr[1] ? w[15:0] : w[31:16];
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'h0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'h0, h};
            default: return w;
        endcase
    endfunction

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        word_t data;
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = OP_FETCH;
        cmd_addr = '0;
        cmd_wdata = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < STEPS; i++) begin
            data = $random(seed);
            if (STEP_OP[i] == OP_SW) begin
                // Mixed sign bits across bytes and halves
                data[31] = 1'b1;
                data[23] = 1'b0;
                data[15] = 1'b0;
                data[7] = 1'b1;
            end
            if (STEP_OP[i] == OP_SH) begin
                // Negative upper half, positive lower half
                data[15] = !STEP_ADDR[i][1];
            end
            if (STEP_OP[i] inside {OP_SW, OP_SH, OP_SB}) begin
                store_to_model(STEP_OP[i], STEP_ADDR[i], data);
            end else begin
                expected_q.push_back(expected_load(STEP_OP[i], STEP_ADDR[i]));
                load_count++;
            end
            cmd_valid <= 1'b1;
            cmd_op    <= STEP_OP[i];
            cmd_addr  <= STEP_ADDR[i];
            cmd_wdata <= data;
            // Transfer at the first edge that sees cmd_ready
            @(negedge clk);
            while (!cmd_ready) @(negedge clk);
            @(posedge clk);
        end
        cmd_valid <= 1'b0;
        while (expected_q.size() != 0) @(posedge clk);
        @(negedge clk);
        if (lsu_top_i.lsu_access_i.lsu_assert_i.violations == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Bus assertions failed %0d times",
                     lsu_top_i.lsu_access_i.lsu_assert_i.violations);
            $display("Errors found");
            $fatal(1, "Bus protocol violation");
        end
    end

    // ------------------------------
    // Response check in command order
    // ------------------------------

    always @(negedge clk) begin
        word_t expected;
        if (!reset && rsp_valid) begin
            assert (expected_q.size() > 0) else begin
                $display("A response arrived with no fetch or load pending");
                $display("Errors found");
                $fatal(1, "Unexpected response");
            end
            expected = expected_q.pop_front();
            assert (rsp_data === expected) else begin
                $display("FAIL %0t: response %0d is %h, expected %h",
                         $time, rsp_count, rsp_data, expected);
                $display("Errors found");
                $fatal(1, "Response mismatch");
            end
            rsp_count++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, responses stopped at %0d of %0d",
                     cycles, rsp_count, load_count);
            $display("Errors found");
            $fatal(1, "Timeout");
        end
    end

endmodule

// ==== build.f ====
+incdir+common
common/lsu_pkg.sv
hdl/lsu_issue.sv
hdl/lsu_access.sv
hdl/lsu_align.sv
mem/data_mem.sv
hdl/lsu_top.sv
tests/lsu_assert.sv
tests/lsu_tb.sv
